//--- compile.f
design/cache_pkg.sv
design/mshr_pkg.sv
design/miss_intake.sv
design/mshr_queue.sv
design/fill_stage.sv
design/mshr_top.sv
dv/tb_clock.sv
dv/mem_model.sv
dv/mshr_tb.sv

//--- design/cache_pkg.sv
package cache_pkg;

  // byte address and the pieces carved from it
  localparam int addr_bits = 32;
  localparam int line_bits = 29;
  localparam int half_bits = 32;

  typedef logic [addr_bits-1:0] addr_t;

  // line number is addr[31:3]; addr[2] picks the half
  typedef logic [line_bits-1:0] line_t;

  typedef logic [half_bits-1:0] half_t;

  // one cache line; whole dword for memory and fill data,
  // two halves when a store merges into it
  typedef union packed {
    logic [2*half_bits-1:0]   dword;
    logic [1:0][half_bits-1:0] half;
  } line_word_u;

  typedef enum logic {
    kind_load,
    kind_store
  } req_kind_t;

  typedef enum logic {
    mem_read,
    mem_write
  } mem_cmd_t;

endpackage

//--- design/fill_stage.sv
`timescale 1ns/1ps

module fill_stage
  import cache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        done_valid,
  output logic        done_ready,
  input  addr_t       done_addr,
  input  logic [63:0] done_data,
  input  logic        done_dirty,
  output logic        fill_valid,
  input  logic        fill_ready,
  output addr_t       fill_addr,
  output logic [63:0] fill_data,
  output logic        fill_dirty
);

  addr_t       slot_addr  [2];
  logic [63:0] slot_data  [2];
  logic        slot_dirty [2];

  logic [1:0] count;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       push;
  logic       pop;

  assign done_ready = (count != 2'd2);
  assign fill_valid = (count != 2'd0);
  assign push       = done_valid && done_ready;
  assign pop        = fill_valid && fill_ready;

  assign fill_addr  = slot_addr[rd_ptr];
  assign fill_data  = slot_data[rd_ptr];
  assign fill_dirty = slot_dirty[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      count  <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (push) wr_ptr <= !wr_ptr;
      if (pop)  rd_ptr <= !rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      slot_addr[wr_ptr]  <= done_addr;
      slot_data[wr_ptr]  <= done_data;
      slot_dirty[wr_ptr] <= done_dirty;
    end
  end

  a_fill_hold: assert property (@(posedge clock) disable iff (reset)
    fill_valid && !fill_ready |=> fill_valid && $stable(fill_data) && $stable(fill_addr));

endmodule

//--- design/miss_intake.sv
`timescale 1ns/1ps

module miss_intake
  import cache_pkg::*;
  import mshr_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      req_valid,
  output logic      req_ready,
  input  addr_t     req_addr,
  input  req_kind_t req_kind,
  input  half_t     req_data,
  output line_t     look_line,
  input  logic      look_hit,
  input  tag_t      look_tag,
  output logic      act_valid,
  input  logic      act_ready,
  output logic [1:0] act_op,
  output req_kind_t act_kind,
  output addr_t     act_addr,
  output half_t     act_data,
  output tag_t      act_tag
);

  logic      held_valid;
  addr_t     held_addr;
  req_kind_t held_kind;
  half_t     held_data;
  logic      act_fire;

  assign act_fire  = act_valid && act_ready;
  assign req_ready = !held_valid || act_fire;

  // valid bit of the holding register
  always_ff @(posedge clock) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (req_ready) begin
      held_valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      held_addr <= req_addr;
      held_kind <= req_kind;
      held_data <= req_data;
    end
  end

  assign look_line = held_addr[31:3];

  // hit on a pending load: loads ride along, stores fold in
  always_comb begin
    if (!look_hit) begin
      act_op = op_alloc;
    end else if (held_kind == kind_load) begin
      act_op = op_coalesce;
    end else begin
      act_op = op_merge;
    end
  end

  assign act_valid = held_valid;
  assign act_kind  = held_kind;
  assign act_addr  = held_addr;
  assign act_data  = held_data;
  assign act_tag   = look_tag;

  a_act_hold: assert property (@(posedge clock) disable iff (reset)
    act_valid && !act_ready |=> act_valid && $stable(act_addr) &&
                                $stable(act_kind) && $stable(act_data));

endmodule

//--- design/mshr_pkg.sv
package mshr_pkg;

  localparam int mshr_depth = 4;

  // entry index doubles as the memory tag
  localparam int tag_bits = $clog2(mshr_depth);

  typedef logic [tag_bits-1:0] tag_t;

  typedef enum logic [1:0] {
    st_free,
    st_waiting,
    st_issued,
    st_done
  } entry_state_t;

  // what the intake asks the queue to do with a miss
  localparam logic [1:0] op_alloc    = 2'd0;
  localparam logic [1:0] op_merge    = 2'd1;
  localparam logic [1:0] op_coalesce = 2'd2;

endpackage

//--- design/mshr_queue.sv
`timescale 1ns/1ps

module mshr_queue
  import cache_pkg::*;
  import mshr_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  line_t       look_line,
  output logic        look_hit,
  output tag_t        look_tag,
  input  logic        act_valid,
  output logic        act_ready,
  input  logic [1:0]  act_op,
  input  req_kind_t   act_kind,
  input  addr_t       act_addr,
  input  half_t       act_data,
  input  tag_t        act_tag,
  output logic        mem_cmd_valid,
  input  logic        mem_cmd_ready,
  output mem_cmd_t    mem_cmd,
  output addr_t       mem_addr,
  output half_t       mem_wdata,
  output tag_t        mem_tag,
  input  logic        mem_rsp_valid,
  input  tag_t        mem_rsp_tag,
  input  logic [63:0] mem_rsp_data,
  output logic        done_valid,
  input  logic        done_ready,
  output addr_t       done_addr,
  output logic [63:0] done_data,
  output logic        done_dirty
);

  entry_state_t ent_state [mshr_depth];
  req_kind_t    ent_kind  [mshr_depth];
  addr_t        ent_addr  [mshr_depth];
  line_word_u   ent_data  [mshr_depth];
  logic [1:0]   ent_mask  [mshr_depth];

  tag_t alloc_ptr;
  tag_t issue_ptr;
  tag_t retire_ptr;
  // live window from retire_ptr up to alloc_ptr, freed writes included
  logic [tag_bits:0] used;

  logic       alloc_fire;
  logic       merge_fire;
  logic       issue_fire;
  logic       retire_fire;
  logic       skip_fire;
  logic       retire_step;
  line_word_u issue_word;
  line_word_u rsp_word;

  // only an alloc can stall
  assign act_ready  = (act_op != op_alloc) || (used != mshr_depth);
  assign alloc_fire = act_valid && act_ready && (act_op == op_alloc);
  assign merge_fire = act_valid && (act_op == op_merge);

  // oldest unissued entry drives the command port
  assign issue_word    = ent_data[issue_ptr];
  assign mem_cmd_valid = (ent_state[issue_ptr] == st_waiting);
  assign mem_cmd       = (ent_kind[issue_ptr] == kind_store) ? mem_write : mem_read;
  assign mem_addr      = ent_addr[issue_ptr];
  assign mem_wdata     = issue_word.half[ent_addr[issue_ptr][2]];
  assign mem_tag       = issue_ptr;
  assign issue_fire    = mem_cmd_valid && mem_cmd_ready;

  assign rsp_word.dword = mem_rsp_data;

  // in-order retirement, freed write entries are stepped over
  assign done_valid  = (used != '0) && (ent_state[retire_ptr] == st_done);
  assign done_addr   = {ent_addr[retire_ptr][31:3], 3'b000};
  assign done_data   = ent_data[retire_ptr].dword;
  assign done_dirty  = |ent_mask[retire_ptr];
  assign retire_fire = done_valid && done_ready;
  assign skip_fire   = (used != '0) && (ent_state[retire_ptr] == st_free);
  assign retire_step = retire_fire || skip_fire;

  // line lookup over pending loads, ignoring one that leaves this edge
  always_comb begin
    look_hit = 1'b0;
    look_tag = '0;
    for (int i = 0; i < mshr_depth; i++) begin
      if (ent_state[i] != st_free && ent_kind[i] == kind_load &&
          ent_addr[i][31:3] == look_line &&
          !(retire_fire && retire_ptr == tag_t'(i))) begin
        look_hit = 1'b1;
        look_tag = tag_t'(i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < mshr_depth; i++) begin
        ent_state[i] <= st_free;
      end
      alloc_ptr  <= '0;
      issue_ptr  <= '0;
      retire_ptr <= '0;
      used       <= '0;
    end else begin
      if (alloc_fire) begin
        ent_state[alloc_ptr] <= st_waiting;
        alloc_ptr <= alloc_ptr + 1'b1;
      end
      // writes are finished once memory takes them
      if (issue_fire) begin
        ent_state[issue_ptr] <= (ent_kind[issue_ptr] == kind_store) ? st_free : st_issued;
        issue_ptr <= issue_ptr + 1'b1;
      end
      if (mem_rsp_valid && ent_state[mem_rsp_tag] == st_issued) begin
        ent_state[mem_rsp_tag] <= st_done;
      end
      if (retire_step) begin
        if (retire_fire) begin
          ent_state[retire_ptr] <= st_free;
        end
        retire_ptr <= retire_ptr + 1'b1;
      end
      case ({alloc_fire, retire_step})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_fire) begin
      ent_kind[alloc_ptr] <= act_kind;
      ent_addr[alloc_ptr] <= act_addr;
      ent_mask[alloc_ptr] <= 2'b00;
      ent_data[alloc_ptr].half[act_addr[2]] <= act_data;
    end
    // memory fills only the halves no store has claimed
    if (mem_rsp_valid) begin
      for (int h = 0; h < 2; h++) begin
        if (!ent_mask[mem_rsp_tag][h]) begin
          ent_data[mem_rsp_tag].half[h] <= rsp_word.half[h];
        end
      end
    end
    // after the response, so a merge on the same edge wins
    if (merge_fire) begin
      ent_data[act_tag].half[act_addr[2]] <= act_data;
      ent_mask[act_tag][act_addr[2]] <= 1'b1;
    end
  end

  a_rsp_issued: assert property (@(posedge clock) disable iff (reset)
    mem_rsp_valid |-> ent_state[mem_rsp_tag] == st_issued);

  // occupancy count and entry states must agree on the free slot
  a_alloc_free: assert property (@(posedge clock) disable iff (reset)
    alloc_fire |-> ent_state[alloc_ptr] == st_free);

endmodule

//--- design/mshr_top.sv
`timescale 1ns/1ps

module mshr_top
  import cache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  output logic        req_ready,
  input  addr_t       req_addr,
  input  req_kind_t   req_kind,
  input  half_t       req_data,
  output logic        mem_cmd_valid,
  input  logic        mem_cmd_ready,
  output mem_cmd_t    mem_cmd,
  output addr_t       mem_addr,
  output half_t       mem_wdata,
  output logic [1:0]  mem_tag,
  input  logic        mem_rsp_valid,
  input  logic [1:0]  mem_rsp_tag,
  input  logic [63:0] mem_rsp_data,
  output logic        fill_valid,
  input  logic        fill_ready,
  output addr_t       fill_addr,
  output logic [63:0] fill_data,
  output logic        fill_dirty
);

  // intake to queue
  line_t      look_line;
  logic       look_hit;
  logic [1:0] look_tag;
  logic       act_valid;
  logic       act_ready;
  logic [1:0] act_op;
  req_kind_t  act_kind;
  addr_t      act_addr;
  half_t      act_data;
  logic [1:0] act_tag;

  // queue to fill stage
  logic        done_valid;
  logic        done_ready;
  addr_t       done_addr;
  logic [63:0] done_data;
  logic        done_dirty;

  miss_intake intake0 (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .req_kind  (req_kind),
    .req_data  (req_data),
    .look_line (look_line),
    .look_hit  (look_hit),
    .look_tag  (look_tag),
    .act_valid (act_valid),
    .act_ready (act_ready),
    .act_op    (act_op),
    .act_kind  (act_kind),
    .act_addr  (act_addr),
    .act_data  (act_data),
    .act_tag   (act_tag)
  );

  mshr_queue queue0 (
    .clock         (clock),
    .reset         (reset),
    .look_line     (look_line),
    .look_hit      (look_hit),
    .look_tag      (look_tag),
    .act_valid     (act_valid),
    .act_ready     (act_ready),
    .act_op        (act_op),
    .act_kind      (act_kind),
    .act_addr      (act_addr),
    .act_data      (act_data),
    .act_tag       (act_tag),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd       (mem_cmd),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_tag       (mem_tag),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_tag   (mem_rsp_tag),
    .mem_rsp_data  (mem_rsp_data),
    .done_valid    (done_valid),
    .done_ready    (done_ready),
    .done_addr     (done_addr),
    .done_data     (done_data),
    .done_dirty    (done_dirty)
  );

  fill_stage fill0 (
    .clock      (clock),
    .reset      (reset),
    .done_valid (done_valid),
    .done_ready (done_ready),
    .done_addr  (done_addr),
    .done_data  (done_data),
    .done_dirty (done_dirty),
    .fill_valid (fill_valid),
    .fill_ready (fill_ready),
    .fill_addr  (fill_addr),
    .fill_data  (fill_data),
    .fill_dirty (fill_dirty)
  );

endmodule

//--- dv/mem_model.sv
`timescale 1ns/1ps

module mem_model
  import cache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        hold,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  mem_cmd_t    cmd,
  input  addr_t       addr,
  input  half_t       wdata,
  input  logic [1:0]  tag,
  output logic        rsp_valid,
  output logic [1:0]  rsp_tag,
  output logic [63:0] rsp_data,
  output int          write_count
);

  // reads in flight, one slot per accepted read
  logic [1:0]  pend_tag  [$];
  logic [28:0] pend_line [$];
  int          pend_wait [$];

  // upper half is the line xor a pattern, lower half its complement
  function automatic logic [63:0] read_word(logic [28:0] line);
    return {{3'b000, line} ^ 32'h5a5a5a5a, {3'b000, ~line}};
  endfunction

  initial begin
    int   ready_count;
    int   pick;
    logic hold_seen;
    logic reset_seen;
    cmd_ready   = 1'b0;
    rsp_valid   = 1'b0;
    rsp_tag     = '0;
    rsp_data    = '0;
    write_count = 0;
    forever begin
      @(posedge clock);
      hold_seen  = hold;
      reset_seen = reset;
      if (reset_seen) begin
        pend_tag.delete();
        pend_line.delete();
        pend_wait.delete();
      end else begin
        for (int i = 0; i < pend_wait.size(); i++) begin
          if (pend_wait[i] > 0) pend_wait[i] = pend_wait[i] - 1;
        end
        if (cmd_valid && cmd_ready) begin
          if (cmd == mem_write) begin
            write_count++;
            $display("mem write %h <= %h", addr, wdata);
          end else begin
            pend_tag.push_back(tag);
            pend_line.push_back(addr[31:3]);
            pend_wait.push_back(1 + int'($urandom % 6));
          end
        end
      end
      #1;
      rsp_valid = 1'b0;
      cmd_ready = !reset_seen && ($urandom % 4 != 0);
      // answer one expired read per cycle, picked at random
      if (!reset_seen && !hold_seen) begin
        ready_count = 0;
        for (int i = 0; i < pend_wait.size(); i++) begin
          if (pend_wait[i] == 0) ready_count++;
        end
        if (ready_count != 0) begin
          pick = int'($urandom % ready_count);
          for (int i = 0; i < pend_wait.size(); i++) begin
            if (pend_wait[i] == 0) begin
              if (pick == 0) begin
                rsp_valid = 1'b1;
                rsp_tag   = pend_tag[i];
                rsp_data  = read_word(pend_line[i]);
                pend_tag.delete(i);
                pend_line.delete(i);
                pend_wait.delete(i);
                break;
              end
              pick--;
            end
          end
        end
      end
    end
  end

endmodule

//--- dv/mshr_tb.sv
`timescale 1ns/1ps

module mshr_tb
  import cache_pkg::*;
();

  // what a row should cause at the memory port
  localparam logic [1:0] fx_none  = 2'd0;
  localparam logic [1:0] fx_read  = 2'd1;
  localparam logic [1:0] fx_write = 2'd2;

  typedef struct packed {
    addr_t      addr;
    req_kind_t  kind;
    half_t      data;
    logic       hold;
    logic [1:0] effect;
  } row_t;

  typedef struct packed {
    mem_cmd_t   cmd;
    addr_t      addr;
    half_t      data;
    logic [1:0] tag;
  } cmd_t;

  typedef struct packed {
    addr_t       addr;
    logic [63:0] data;
    logic        dirty;
  } fill_t;

  logic        clock;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  addr_t       req_addr;
  req_kind_t   req_kind;
  half_t       req_data;
  logic        mem_cmd_valid;
  logic        mem_cmd_ready;
  mem_cmd_t    mem_cmd;
  addr_t       mem_addr;
  half_t       mem_wdata;
  logic [1:0]  mem_tag;
  logic        mem_rsp_valid;
  logic [1:0]  mem_rsp_tag;
  logic [63:0] mem_rsp_data;
  logic        fill_valid;
  logic        fill_ready;
  addr_t       fill_addr;
  logic [63:0] fill_data;
  logic        fill_dirty;
  logic        hold;
  int          write_count;

  row_t  rows [$];
  cmd_t  exp_cmds [$];
  fill_t exp_fills [$];
  int    mismatches;
  int    other_errors;
  int    alloc_count;
  int    exp_writes;
  logic  saw_stall;

  tb_clock clock0 (.clock(clock));

  mem_model mem0 (
    .clock       (clock),
    .reset       (reset),
    .hold        (hold),
    .cmd_valid   (mem_cmd_valid),
    .cmd_ready   (mem_cmd_ready),
    .cmd         (mem_cmd),
    .addr        (mem_addr),
    .wdata       (mem_wdata),
    .tag         (mem_tag),
    .rsp_valid   (mem_rsp_valid),
    .rsp_tag     (mem_rsp_tag),
    .rsp_data    (mem_rsp_data),
    .write_count (write_count)
  );

  mshr_top dut0 (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_addr      (req_addr),
    .req_kind      (req_kind),
    .req_data      (req_data),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd       (mem_cmd),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_tag       (mem_tag),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_tag   (mem_rsp_tag),
    .mem_rsp_data  (mem_rsp_data),
    .fill_valid    (fill_valid),
    .fill_ready    (fill_ready),
    .fill_addr     (fill_addr),
    .fill_data     (fill_data),
    .fill_dirty    (fill_dirty)
  );

  function automatic logic [63:0] mem_word(logic [28:0] line);
    return {{3'b000, line} ^ 32'h5a5a5a5a, {3'b000, ~line}};
  endfunction

  task automatic add_row(addr_t a, req_kind_t k, half_t d, logic h, logic [1:0] e);
    rows.push_back(row_t'{a, k, d, h, e});
  endtask

  // one row per miss with the memory command it should cause
  task automatic load_table();
    add_row(32'h0000_1000, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0000_2004, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0000_3008, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0000_4004, kind_store, 32'hdead_beef, 1'b0, fx_write);
    add_row(32'h0000_5000, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0000_6000, kind_store, 32'h1234_5678, 1'b0, fx_write);
    add_row(32'h0000_7010, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0000_8018, kind_load,  32'h0000_0000, 1'b0, fx_read);
    // held groups for a merge, a coalesce and a line with both halves merged
    add_row(32'h0001_0000, kind_load,  32'h0000_0000, 1'b1, fx_read);
    add_row(32'h0001_0004, kind_store, 32'hcafe_f00d, 1'b1, fx_none);
    add_row(32'h0002_0008, kind_load,  32'h0000_0000, 1'b1, fx_read);
    add_row(32'h0002_000c, kind_load,  32'h0000_0000, 1'b1, fx_none);
    add_row(32'h0003_0000, kind_load,  32'h0000_0000, 1'b1, fx_read);
    add_row(32'h0003_0000, kind_store, 32'h0bad_cafe, 1'b1, fx_none);
    add_row(32'h0003_0004, kind_load,  32'h0000_0000, 1'b1, fx_none);
    add_row(32'h0003_0004, kind_store, 32'h600d_f00d, 1'b1, fx_none);
    // a load behind a store to the same line still reads memory
    add_row(32'h0004_0000, kind_store, 32'h0000_0001, 1'b0, fx_write);
    add_row(32'h0004_0000, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0005_0000, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0006_0004, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0007_0008, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h0008_0000, kind_store, 32'h8765_4321, 1'b0, fx_write);
    add_row(32'h0009_0004, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h000a_0000, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h000b_0008, kind_load,  32'h0000_0000, 1'b0, fx_read);
    add_row(32'h000c_0000, kind_load,  32'h0000_0000, 1'b0, fx_read);
  endtask

  // expected traffic for an accepted row with tags in allocation order
  task automatic predict(input row_t r);
    fill_t f;
    int    hit;
    hit = -1;
    case (r.effect)
      fx_read: begin
        exp_cmds.push_back(cmd_t'{mem_read, r.addr, 32'h0, 2'(alloc_count % 4)});
        exp_fills.push_back(fill_t'{{r.addr[31:3], 3'b000}, mem_word(r.addr[31:3]), 1'b0});
        alloc_count++;
      end
      fx_write: begin
        exp_cmds.push_back(cmd_t'{mem_write, r.addr, r.data, 2'(alloc_count % 4)});
        exp_writes++;
        alloc_count++;
      end
      default: begin
        if (r.kind == kind_store) begin
          for (int i = 0; i < exp_fills.size(); i++) begin
            if (exp_fills[i].addr[31:3] == r.addr[31:3]) hit = i;
          end
          if (hit < 0) begin
            $display("store to %h has no pending load to merge into", r.addr);
            other_errors++;
          end else begin
            f = exp_fills[hit];
            if (r.addr[2]) f.data[63:32] = r.data;
            else f.data[31:0] = r.data;
            f.dirty = 1'b1;
            exp_fills[hit] = f;
          end
        end
      end
    endcase
  endtask

  task automatic send_row(input row_t r);
    req_valid = 1'b1;
    req_addr  = r.addr;
    req_kind  = r.kind;
    req_data  = r.data;
    @(posedge clock);
    while (!req_ready) begin
      saw_stall = 1'b1;
      @(posedge clock);
    end
    predict(r);
    #1;
    req_valid = 1'b0;
  endtask

  // wait until every predicted command and fill has been seen
  task automatic drain();
    while (exp_cmds.size() != 0 || exp_fills.size() != 0) @(posedge clock);
    #1;
  endtask

  always @(posedge clock) begin
    cmd_t c;
    if (!reset && mem_cmd_valid && mem_cmd_ready) begin
      if (exp_cmds.size() == 0) begin
        $display("unexpected memory command to %h", mem_addr);
        other_errors++;
      end else begin
        c = exp_cmds.pop_front();
        if (mem_cmd !== c.cmd) begin
          $display("Mismatch mem_cmd: expected %h, got %h", c.cmd, mem_cmd);
          mismatches++;
        end
        if (mem_addr !== c.addr) begin
          $display("Mismatch mem_addr: expected %h, got %h", c.addr, mem_addr);
          mismatches++;
        end
        if (mem_tag !== c.tag) begin
          $display("Mismatch mem_tag: expected %h, got %h", c.tag, mem_tag);
          mismatches++;
        end
        if (c.cmd == mem_write && mem_wdata !== c.data) begin
          $display("Mismatch mem_wdata: expected %h, got %h", c.data, mem_wdata);
          mismatches++;
        end
      end
    end
  end

  always @(posedge clock) begin
    fill_t f;
    if (!reset && fill_valid && fill_ready) begin
      if (exp_fills.size() == 0) begin
        $display("unexpected fill for %h", fill_addr);
        other_errors++;
      end else begin
        f = exp_fills.pop_front();
        if (fill_addr !== f.addr) begin
          $display("Mismatch fill_addr: expected %h, got %h", f.addr, fill_addr);
          mismatches++;
        end
        if (fill_data !== f.data) begin
          $display("Mismatch fill_data: expected %h, got %h", f.data, fill_data);
          mismatches++;
        end
        if (fill_dirty !== f.dirty) begin
          $display("Mismatch fill_dirty: expected %h, got %h", f.dirty, fill_dirty);
          mismatches++;
        end
      end
    end
  end

  // long fill port stalls between short windows of progress
  initial begin
    fill_ready = 1'b0;
    repeat (80) @(posedge clock);
    forever begin
      #1;
      fill_ready = 1'b1;
      repeat (1 + $urandom % 8) @(posedge clock);
      #1;
      fill_ready = 1'b0;
      repeat (20 + $urandom % 40) @(posedge clock);
    end
  end

  // budget of 200 cycles per row on top of reset
  initial begin
    #1;
    repeat (16 + 200 * rows.size()) @(posedge clock);
    $display("timeout with %0d memory commands and %0d fills still outstanding",
             exp_cmds.size(), exp_fills.size());
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    load_table();
    void'($urandom(32'h76004131));
    mismatches   = 0;
    other_errors = 0;
    alloc_count  = 0;
    exp_writes   = 0;
    saw_stall    = 1'b0;
    reset        = 1'b1;
    hold         = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_kind     = kind_load;
    req_data     = '0;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    if (req_ready !== 1'b1) begin
      $display("Mismatch req_ready after reset: expected 1, got %h", req_ready);
      mismatches++;
    end
    if (mem_cmd_valid !== 1'b0) begin
      $display("Mismatch mem_cmd_valid after reset: expected 0, got %h", mem_cmd_valid);
      mismatches++;
    end
    if (fill_valid !== 1'b0) begin
      $display("Mismatch fill_valid after reset: expected 0, got %h", fill_valid);
      mismatches++;
    end
    // a held group starts on an empty queue so its load cannot answer early
    for (int r = 0; r < rows.size(); r++) begin
      if (rows[r].hold && !hold) drain();
      hold = rows[r].hold;
      send_row(rows[r]);
    end
    hold = 1'b0;
    drain();
    repeat (20) @(posedge clock);
    if (fill_valid !== 1'b0) begin
      $display("a fill is still waiting after all expected fills were seen");
      other_errors++;
    end
    if (write_count != exp_writes) begin
      $display("memory logged %0d writes where %0d were expected", write_count, exp_writes);
      other_errors++;
    end
    if (!saw_stall) begin
      $display("req_ready never dropped while fills were stalled");
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clock
);

  // 10 ns period
  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build the MSHR testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mshr_tb -f compile.f -o mshr_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mshr_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  exit 1
fi
exit 0
